// File: bench/dcache_model.svh
// reference model of backing memory and of the cache tags, dirty bits and lru bits
`ifndef DCACHE_MODEL_SVH
`define DCACHE_MODEL_SVH

logic [DATA_W-1:0] backing [logic [ADDR_W-1:0]];    // words written back so far
int unsigned       mem_writes = 0;                  // bumps on every backing write

logic              line_valid [NUM_SETS][NUM_WAYS];
logic              line_dirty [NUM_SETS][NUM_WAYS];
logic [TAG_W-1:0]  line_tag   [NUM_SETS][NUM_WAYS];
logic [DATA_W-1:0] line_data  [NUM_SETS][NUM_WAYS];
logic              set_lru    [NUM_SETS];           // way replaced next

// untouched memory returns a value mixed from every address bit
function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h2545_f491;
endfunction

function automatic logic [DATA_W-1:0] backing_word(input logic [ADDR_W-1:0] a);
    logic [ADDR_W-1:0] wa;
    wa = {a[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
    if (backing.exists(wa)) begin
        return backing[wa];
    end
    return fill_word(wa);
endfunction

task automatic store_backing(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    backing[{a[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}}] = d;
    mem_writes++;
endtask

function automatic logic [DATA_W-1:0] select_byte(input logic [DATA_W-1:0] w,
                                                  input logic [1:0] offs);
    return (w >> (8 * offs)) & 32'h0000_00ff;       // zero-extended lane
endfunction

function automatic logic [DATA_W-1:0] splice_byte(input logic [DATA_W-1:0] w,
                                                  input logic [1:0] offs,
                                                  input logic [7:0] b);
    return (w & ~(32'h0000_00ff << (8 * offs))) | ({24'h0, b} << (8 * offs));
endfunction

task automatic clear_cache_model();
    for (int s = 0; s < NUM_SETS; s++) begin
        set_lru[s] = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            line_valid[s][w] = 1'b0;
            line_dirty[s][w] = 1'b0;
            line_tag[s][w]   = '0;
            line_data[s][w]  = '0;
        end
    end
endtask

// expected outcome of one request, then the model state after it
task automatic predict_access(input cpu_req_t r, output logic hit, output logic wb,
                              output logic [ADDR_W-1:0] wb_addr,
                              output logic [DATA_W-1:0] wb_data,
                              output logic [DATA_W-1:0] ld_data);
    logic [SET_W-1:0]  s;
    logic [DATA_W-1:0] word;
    int                way;
    s       = r.addr.set_idx;
    hit     = 1'b0;
    way     = 0;
    wb      = 1'b0;
    wb_addr = '0;
    wb_data = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
        if (line_valid[s][w] && line_tag[s][w] == r.addr.tag) begin
            hit = 1'b1;
            way = w;
        end
    end
    if (hit) begin
        word = line_data[s][way];
    end else begin
        way = set_lru[s];
        if (line_valid[s][way] && line_dirty[s][way]) begin
            wb      = 1'b1;
            wb_addr = {line_tag[s][way], s, 2'b00};
            wb_data = line_data[s][way];
        end
        word             = backing_word({r.addr.tag, s, 2'b00});
        line_valid[s][way] = 1'b1;
        line_dirty[s][way] = 1'b0;
        line_tag[s][way]   = r.addr.tag;
    end
    if (r.wr_en) begin
        word = r.word ? r.wdata.word : splice_byte(word, r.addr.offs, r.wdata.word[7:0]);
        line_dirty[s][way] = 1'b1;
    end
    line_data[s][way] = word;
    set_lru[s]        = (way == 0);                  // other way goes next
    ld_data           = r.word ? word : select_byte(word, r.addr.offs);
endtask

`endif

// File: bench/dcache_tb.sv
// testbench with clock, reset, random requests, memory responder, checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int          CLK_PERIOD = 100;
    localparam int          RST_CYCLES = 8;
    localparam int          NUM_REQS   = 2000;
    localparam int          MAX_STALL  = 4;
    localparam int          TIMEOUT_NS = (NUM_REQS * (MAX_STALL + 1) + RST_CYCLES + 16)
                                         * CLK_PERIOD;
    localparam logic [31:0] SEED       = 32'h2f18;

    logic              clk       = 1'b0;
    logic              rst       = 1'b1;
    cpu_req_t          req       = '0;
    logic [DATA_W-1:0] mem_rdata = '0;
    logic [DATA_W-1:0] rdata;
    logic              stall;
    logic              miss;
    mem_req_t          mem_req;

    // few tags and sets so that lines keep conflicting
    logic [TAG_W-1:0]  tag_pool [3] = '{22'h0_1a2b, 22'h2_c3d4, 22'h3_f00f};
    logic [SET_W-1:0]  set_pool [4] = '{8'h00, 8'h5a, 8'ha7, 8'hff};

    `include "dcache_model.svh"

    dcache_top u_dut (
        .clk_i       (clk),
        .rst_i       (rst),
        .req_i       (req),
        .mem_rdata_i (mem_rdata),
        .rdata_o     (rdata),
        .stall_o     (stall),
        .miss_o      (miss),
        .mem_req_o   (mem_req)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // memory answers in the same cycle
    always @(mem_req or mem_writes) begin
        mem_rdata = backing_word(mem_req.addr);
    end

    always @(posedge clk) begin
        if (!rst && mem_req.we) begin
            store_backing(mem_req.addr, mem_req.wdata);
        end
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    function automatic cpu_req_t random_req();
        cpu_req_t r;
        r               = '0;
        r.wr_en         = ($urandom_range(0, 1) == 1);
        r.rd_en         = !r.wr_en;
        r.word          = ($urandom_range(0, 1) == 1);
        r.addr.tag      = tag_pool[$urandom_range(0, 2)];
        r.addr.set_idx  = set_pool[$urandom_range(0, 3)];
        r.addr.offs     = r.word ? 2'b00 : 2'($urandom_range(0, 3));
        r.wdata.word    = $urandom;
        return r;
    endfunction

    initial begin
        #(TIMEOUT_NS);
        report_failure("timeout: the cache did not finish all requests in time");
    end

    initial begin
        cpu_req_t          cur;
        logic              exp_hit;
        logic              exp_wb;
        logic [ADDR_W-1:0] exp_wb_addr;
        logic [DATA_W-1:0] exp_wb_data;
        logic [DATA_W-1:0] exp_ld;
        logic [ADDR_W-1:0] fill_addr;
        int                cycles;
        int                exp_stall;
        void'($urandom(SEED));
        clear_cache_model();
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_value("stall_o", stall, 1'b0);          // idle outputs after reset
        compare_value("miss_o", miss, 1'b0);
        compare_value("mem_req_o.we", mem_req.we, 1'b0);
        compare_value("rdata_o", rdata, '0);

        for (int n = 0; n < NUM_REQS; n++) begin
            @(posedge clk);
            cur = random_req();
            req <= cur;
            predict_access(cur, exp_hit, exp_wb, exp_wb_addr, exp_wb_data, exp_ld);
            fill_addr = {cur.addr.tag, cur.addr.set_idx, 2'b00};
            exp_stall = exp_hit ? 0 : (exp_wb ? 4 : 3);
            @(negedge clk);
            cycles = 0;
            while (stall) begin
                compare_value("miss_o", miss, 1'b1);
                if (exp_wb && cycles == 1) begin
                    compare_value("mem_req_o.we", mem_req.we, 1'b1);
                    compare_value("mem_req_o.addr", mem_req.addr, exp_wb_addr);
                    compare_value("mem_req_o.wdata", mem_req.wdata, exp_wb_data);
                end else begin
                    compare_value("mem_req_o.we", mem_req.we, 1'b0);
                    if (cycles > 0) begin
                        compare_value("mem_req_o.addr", mem_req.addr, fill_addr);
                    end
                end
                if (cycles == exp_stall - 1 && cur.rd_en) begin
                    compare_value("rdata_o", rdata, exp_ld);     // update cycle
                end
                cycles++;
                if (cycles > MAX_STALL) begin
                    report_failure("stall_o stayed high longer than any miss can take");
                end
                @(negedge clk);
            end
            compare_value("stall_o cycles", cycles, exp_stall);
            // a plain hit, or the held request hitting after the fill
            compare_value("miss_o", miss, 1'b0);
            compare_value("mem_req_o.we", mem_req.we, 1'b0);
            if (cur.rd_en) begin
                compare_value("rdata_o", rdata, exp_ld);
            end
        end

        @(posedge clk);
        req <= '0;
        @(negedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/dcache_lookup.sv
// tag compare, hit way, victim choice and hit load data formatting
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup (
    input  wire dcache_pkg::cpu_req_t       req_i,
    input  wire dcache_pkg::set_t           set_i,
    output logic                            hit_o,
    output logic                            hit_way_o,
    output logic                            victim_way_o,
    output logic                            victim_dirty_o,
    output logic [dcache_pkg::TAG_W-1:0]    victim_tag_o,
    output logic [dcache_pkg::DATA_W-1:0]   hit_rdata_o
);
    import dcache_pkg::*;

    addr_t               addr;
    logic                access;
    logic [NUM_WAYS-1:0] way_match;
    line_t               victim;
    data_u               hit_word;

    assign addr   = req_i.addr;
    assign access = req_i.rd_en || req_i.wr_en;

    // a way matches only while it holds a valid line
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_match[w] = set_i.ways[w].valid && (set_i.ways[w].tag == addr.tag);
        end
    end

    assign hit_o     = access && (|way_match);
    assign hit_way_o = way_match[1];        // way 0 when nothing matches

    // victim comes straight from the lru bit
    assign victim_way_o   = set_i.lru;
    assign victim         = set_i.ways[set_i.lru];
    assign victim_dirty_o = victim.valid && victim.dirty;   // invalid lines never write back
    assign victim_tag_o   = victim.tag;

    assign hit_word = set_i.ways[hit_way_o].data;

    always_comb begin
        if (req_i.word) begin
            hit_rdata_o = hit_word.word;
        end else begin
            hit_rdata_o = byte_extract(hit_word, addr.offs);
        end
    end

endmodule

`default_nettype wire

// File: design/dcache_miss_ctrl.sv
// miss FSM, memory port, stall and load data select
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_ctrl (
    input  wire                             clk_i,
    input  wire                             rst_i,
    input  wire dcache_pkg::cpu_req_t       req_i,
    input  wire                             hit_i,
    input  wire                             victim_dirty_i,
    input  wire [dcache_pkg::TAG_W-1:0]     victim_tag_i,
    input  wire [dcache_pkg::DATA_W-1:0]    victim_data_i,
    input  wire [dcache_pkg::DATA_W-1:0]    hit_rdata_i,
    input  wire [dcache_pkg::DATA_W-1:0]    mem_rdata_i,
    output dcache_pkg::dcache_state_e       state_o,
    output logic                            stall_o,
    output logic                            miss_o,
    output logic [dcache_pkg::DATA_W-1:0]   rdata_o,
    output dcache_pkg::mem_req_t            mem_req_o
);
    import dcache_pkg::*;

    dcache_state_e     state_q;
    dcache_state_e     state_d;
    addr_t             addr;
    logic              access;
    logic              miss;
    logic [DATA_W-1:0] fill_rdata;

    assign addr    = req_i.addr;
    assign access  = req_i.rd_en || req_i.wr_en;
    assign miss    = access && !hit_i;
    assign state_o = state_q;

    // idle -> [writeback] -> fetch -> update -> idle
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (miss) begin
                    state_d = victim_dirty_i ? WRITEBACK : FETCH;
                end
            end
            WRITEBACK: begin
                state_d = FETCH;
            end
            FETCH: begin
                state_d = UPDATE;
            end
            UPDATE: begin
                state_d = IDLE;             // held request hits on return
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // the lookup keeps missing until the fill lands, so miss_o covers the whole sequence
    assign miss_o  = miss;
    assign stall_o = (state_q != IDLE) || miss;

    always_comb begin
        mem_req_o.we    = 1'b0;
        mem_req_o.addr  = addr;
        mem_req_o.wdata = '0;
        case (state_q)
            WRITEBACK: begin
                // old line goes back to its own address
                mem_req_o.we    = 1'b1;
                mem_req_o.addr  = {victim_tag_i, addr.set_idx, {OFFS_W{1'b0}}};
                mem_req_o.wdata = victim_data_i;
            end
            FETCH, UPDATE: begin
                mem_req_o.addr = {addr.tag, addr.set_idx, {OFFS_W{1'b0}}};   // held for the fill
            end
            default: begin
                mem_req_o.we = 1'b0;
            end
        endcase
    end

    // fetched word shaped like a hit
    assign fill_rdata = req_i.word ? mem_rdata_i : byte_extract(mem_rdata_i, addr.offs);

    always_comb begin
        case (state_q)
            IDLE: begin
                rdata_o = hit_i ? hit_rdata_i : '0;
            end
            UPDATE: begin
                rdata_o = fill_rdata;
            end
            default: begin
                rdata_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/dcache_pkg.sv
// cache widths, address fields, request and line structs, data union, byte helpers
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int BYTE_W   = 8;
    localparam int SET_W    = 8;
    localparam int OFFS_W   = 2;
    localparam int TAG_W    = ADDR_W - SET_W - OFFS_W;  // 22
    localparam int NUM_SETS = 1 << SET_W;
    localparam int NUM_WAYS = 2;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [SET_W-1:0]  set_idx;
        logic [OFFS_W-1:0] offs;
    } addr_t;

    // whole word for word accesses, byte lanes for extract and merge
    typedef union packed {
        logic [DATA_W-1:0]                      word;
        logic [DATA_W/BYTE_W-1:0][BYTE_W-1:0]   bytes;
    } data_u;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
        data_u            data;
    } line_t;                               // 56 bits

    // lru = 0 means way 0 is the next victim
    typedef struct packed {
        logic                     lru;
        line_t [NUM_WAYS-1:0]     ways;
    } set_t;                                // 113 bits

    typedef struct packed {
        logic  rd_en;
        logic  wr_en;
        logic  word;                        // 0 selects a byte access
        addr_t addr;
        data_u wdata;
    } cpu_req_t;                            // 67 bits

    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;                            // 65 bits

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        FETCH,
        UPDATE
    } dcache_state_e;

    // zero-extended byte at the given offset
    function automatic logic [DATA_W-1:0] byte_extract(input data_u w, input logic [OFFS_W-1:0] offs);
        byte_extract = {{(DATA_W-BYTE_W){1'b0}}, w.bytes[offs]};
    endfunction

    function automatic data_u byte_merge(input data_u w, input logic [OFFS_W-1:0] offs,
                                         input logic [BYTE_W-1:0] b);
        data_u merged;
        merged = w;
        merged.bytes[offs] = b;             // other lanes keep their old value
        return merged;
    endfunction

endpackage

`default_nettype wire

// File: design/dcache_set_array.sv
// set storage with hit writes, lru updates and miss fills
`timescale 1ns/1ps
`default_nettype none

module dcache_set_array (
    input  wire                             clk_i,
    input  wire                             rst_i,
    input  wire dcache_pkg::cpu_req_t       req_i,
    input  wire dcache_pkg::dcache_state_e  state_i,
    input  wire                             hit_i,
    input  wire                             hit_way_i,
    input  wire                             victim_way_i,
    input  wire [dcache_pkg::DATA_W-1:0]    mem_rdata_i,
    output dcache_pkg::set_t                set_o
);
    import dcache_pkg::*;

    set_t  sets [NUM_SETS];
    addr_t addr;
    logic  fill;                            // update cycle writes the victim way
    logic  wr_way;
    logic  set_we;
    data_u base_word;
    data_u store_word;
    line_t new_line;
    set_t  next_set;

    assign addr  = req_i.addr;
    assign set_o = sets[addr.set_idx];

    assign fill   = (state_i == UPDATE);
    assign wr_way = fill ? victim_way_i : hit_way_i;

    // a byte store merges into the cached word on a hit, the fetched word on a fill
    assign base_word  = fill ? data_u'(mem_rdata_i) : set_o.ways[wr_way].data;
    assign store_word = req_i.word ? req_i.wdata
                                   : byte_merge(base_word, addr.offs, req_i.wdata.bytes[0]);

    always_comb begin
        new_line = set_o.ways[wr_way];
        next_set = set_o;
        set_we   = 1'b0;
        case (state_i)
            IDLE: begin
                if (hit_i) begin
                    set_we = 1'b1;          // a read hit only moves the lru bit
                    if (req_i.wr_en) begin
                        new_line.dirty = 1'b1;
                        new_line.data  = store_word;
                    end
                end
            end
            UPDATE: begin
                set_we         = 1'b1;
                new_line.valid = 1'b1;
                new_line.dirty = req_i.wr_en;   // loads fill clean
                new_line.tag   = addr.tag;
                if (req_i.wr_en) begin
                    new_line.data = store_word;
                end else begin
                    new_line.data = data_u'(mem_rdata_i);
                end
            end
            default: begin
                set_we = 1'b0;
            end
        endcase
        next_set.ways[wr_way] = new_line;
        next_set.lru          = ~wr_way;    // other way becomes the next victim
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                sets[s] <= '0;              // invalid lines, lru at way 0
            end
        end else if (set_we) begin
            sets[addr.set_idx] <= next_set;
        end
    end

endmodule

`default_nettype wire

// File: design/dcache_top.sv
// data cache top: set array, lookup and miss controller
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  wire                             clk_i,
    input  wire                             rst_i,
    input  wire dcache_pkg::cpu_req_t       req_i,
    input  wire [dcache_pkg::DATA_W-1:0]    mem_rdata_i,
    output logic [dcache_pkg::DATA_W-1:0]   rdata_o,
    output logic                            stall_o,
    output logic                            miss_o,
    output dcache_pkg::mem_req_t            mem_req_o
);
    import dcache_pkg::*;

    set_t              cur_set;             // set addressed by the request
    dcache_state_e     state;
    logic              hit;
    logic              hit_way;
    logic              victim_way;
    logic              victim_dirty;
    logic [TAG_W-1:0]  victim_tag;
    logic [DATA_W-1:0] hit_rdata;

    dcache_set_array u_set_array (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_i        (req_i),
        .state_i      (state),
        .hit_i        (hit),
        .hit_way_i    (hit_way),
        .victim_way_i (victim_way),
        .mem_rdata_i  (mem_rdata_i),
        .set_o        (cur_set)
    );

    dcache_lookup u_lookup (
        .req_i          (req_i),
        .set_i          (cur_set),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag),
        .hit_rdata_o    (hit_rdata)
    );

    dcache_miss_ctrl u_miss_ctrl (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .req_i          (req_i),
        .hit_i          (hit),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .victim_data_i  (cur_set.ways[victim_way].data),   // word written back on a dirty miss
        .hit_rdata_i    (hit_rdata),
        .mem_rdata_i    (mem_rdata_i),
        .state_o        (state),
        .stall_o        (stall_o),
        .miss_o         (miss_o),
        .rdata_o        (rdata_o),
        .mem_req_o      (mem_req_o)
    );

endmodule

`default_nettype wire

// File: tb.f
+incdir+bench
design/dcache_pkg.sv
design/dcache_lookup.sv
design/dcache_set_array.sv
design/dcache_miss_ctrl.sv
design/dcache_top.sv
bench/dcache_tb.sv
